// File: compile.f
dma_pkg.sv
dma_fifo.sv
dma_copy.sv
dma_fill.sv
dma_ctrl.sv
dma_top.sv
dma_assert.sv
tb_dma.sv

// File: dma_assert.sv
//################################################
// dma protocol assertions
// FIFO strobe legality, end pulse width and the
// idle state that follows reset
//################################################

module dma_assert (
   input logic wb_clk_i,
   input logic wb_rst_i,
   input logic src_putn,
   input logic src_getn,
   input logic src_full,
   input logic src_empty,
   input logic dst_putn,
   input logic dst_getn,
   input logic dst_full,
   input logic dst_empty,
   input logic endn,
   input logic busy
);

   // a strobe is only ever low while the matching flag allows the move
   a_src_fifo: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (src_putn || !src_full) && (src_getn || !src_empty))
      else $error("source FIFO strobed past its full or empty flag");

   a_dst_fifo: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (dst_putn || !dst_full) && (dst_getn || !dst_empty))
      else $error("destination FIFO strobed past its full or empty flag");

   a_endn_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !endn |=> endn)
      else $error("endn held low for more than one cycle");

   a_reset_idle: assert property (@(posedge wb_clk_i) wb_rst_i |=> !busy)
      else $error("busy set right after reset");

endmodule

bind dma_top dma_assert u_assert (.*);

// File: dma_copy.sv
//################################################
// dma copy engine
// streams source FIFO words to the destination
// FIFO until a word marked last has been moved
//################################################

module dma_copy (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                go,
   input  dma_pkg::dma_word_t  src_word,
   input  logic                src_empty,
   input  logic                dst_full,
   output logic                src_getn,
   output logic                dst_putn,
   output dma_pkg::dma_word_t  dst_word,
   output logic                endn
);

   typedef enum logic [1:0] {
      S_IDLE = 2'b00,
      S_RUN  = 2'b01,
      S_WAIT = 2'b10,
      S_END  = 2'b11
   } state_t;

   state_t state;
   state_t state_n;
   logic   can_move;
   logic   move;

   // a word can only move when there is one to take and room to put it
   assign can_move = ~src_empty & ~dst_full;
   assign move     = (state == S_RUN) & can_move;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= S_IDLE;
      end else begin
         state <= state_n;
      end
   end

   always_comb begin
      state_n = state;
      case (state)
         S_IDLE: begin
            if (go && can_move) begin
               state_n = S_RUN;
            end
         end
         S_RUN: begin
            if (move && src_word.last) begin
               state_n = S_END;
            end else if (!can_move) begin
               state_n = S_WAIT;
            end
         end
         S_WAIT: begin
            if (can_move) begin
               state_n = S_RUN;
            end
         end
         default: begin
            state_n = S_IDLE;
         end
      endcase
   end

   // both strobes fall together, so the word crosses in one edge
   assign src_getn = ~move;
   assign dst_putn = ~move;
   assign dst_word = src_word;
   assign endn     = (state != S_END);

endmodule

// File: dma_ctrl.sv
//################################################
// dma control block
// holds the descriptor and pattern, starts one
// engine and routes its strobes onto the FIFOs
//################################################

module dma_ctrl (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic                           dc_we,
   input  dma_pkg::dc_t                   dc_in,
   input  logic [63:0]                    pattern_in,
   output logic                           copy_go,
   output logic                           fill_go,
   output logic [dma_pkg::DC_COUNT_W-1:0] fill_count,
   output logic [63:0]                    pattern,
   input  logic                           copy_getn,
   input  logic                           copy_putn,
   input  dma_pkg::dma_word_t             copy_word,
   input  logic                           copy_endn,
   input  logic                           fill_putn,
   input  dma_pkg::dma_word_t             fill_word,
   input  logic                           fill_endn,
   output logic                           src_getn,
   output logic                           dst_putn,
   output dma_pkg::dma_word_t             dst_word,
   output logic                           endn,
   output logic                           busy
);

   dma_pkg::dc_t dc_q;

   // the opcode bits double as the job-in-progress state
   assign busy = dc_q[dma_pkg::DC_COPY_BIT] | dc_q[dma_pkg::DC_FILL_BIT];
   assign endn = copy_endn & fill_endn;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dc_q <= '0;
      end else if (!endn) begin
         dc_q[dma_pkg::DC_COPY_BIT] <= 1'b0;
         dc_q[dma_pkg::DC_FILL_BIT] <= 1'b0;
      end else if (dc_we && !busy) begin
         dc_q <= dc_in;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (dc_we && !busy) begin
         pattern <= pattern_in;
      end
   end

   // copy wins when the host sets both opcode bits
   assign copy_go    = dc_q[dma_pkg::DC_COPY_BIT];
   assign fill_go    = dc_q[dma_pkg::DC_FILL_BIT] & ~copy_go;
   assign fill_count = dc_q[dma_pkg::DC_COUNT_LSB +: dma_pkg::DC_COUNT_W];

   // idle strobes stay high so neither FIFO moves between jobs
   assign src_getn = copy_go ? copy_getn : 1'b1;
   assign dst_putn = copy_go ? copy_putn : (fill_go ? fill_putn : 1'b1);
   assign dst_word = copy_go ? copy_word : fill_word;

endmodule

// File: dma_fifo.sv
//################################################
// dma word FIFO
// circular buffer with active-low put and get
// strobes, flags derived from the occupancy count
//################################################

module dma_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                putn,
   input  dma_pkg::dma_word_t  wr_word,
   input  logic                getn,
   output dma_pkg::dma_word_t  rd_word,
   output logic                empty,
   output logic                almost_empty,
   output logic                full,
   output logic                almost_full
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   dma_pkg::dma_word_t mem [FIFO_DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_put;
   logic          do_get;

   // a strobe that would overflow or underflow is dropped here as well
   assign do_put = ~putn & ~full;
   assign do_get = ~getn & ~empty;

   always_ff @(posedge wb_clk_i) begin
      if (do_put) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   // pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_put) begin
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_get) begin
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_put, do_get})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head of the queue is visible without a read latency
   assign rd_word = mem[rd_ptr];

   assign empty        = (count == '0);
   assign almost_empty = (count <= CW'(1));
   assign full         = (count == CW'(FIFO_DEPTH));
   assign almost_full  = (count >= CW'(FIFO_DEPTH - 1));

endmodule

// File: dma_fill.sv
//################################################
// dma fill engine
// writes the host pattern a counted number of
// times and marks the final word as last
//################################################

module dma_fill (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic                           go,
   input  logic [dma_pkg::DC_COUNT_W-1:0] count,
   input  logic [63:0]                    pattern,
   input  logic                           dst_full,
   output logic                           dst_putn,
   output dma_pkg::dma_word_t             dst_word,
   output logic                           endn
);

   typedef enum logic [1:0] {
      F_IDLE = 2'b00,
      F_RUN  = 2'b01,
      F_END  = 2'b10
   } state_t;

   state_t                           state;
   logic [dma_pkg::DC_COUNT_W-1:0]   remain;
   logic                             put;
   logic                             final_word;

   assign put        = (state == F_RUN) & ~dst_full;
   assign final_word = (remain == dma_pkg::DC_COUNT_W'(1));

   // remain counts the words still to be written in this job
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state  <= F_IDLE;
         remain <= '0;
      end else begin
         case (state)
            F_IDLE: begin
               if (go) begin
                  remain <= count;
                  // an empty job still reports its end
                  state  <= (count == '0) ? F_END : F_RUN;
               end
            end
            F_RUN: begin
               if (put) begin
                  remain <= remain - 1'b1;
                  if (final_word) begin
                     state <= F_END;
                  end
               end
            end
            default: begin
               state <= F_IDLE;
            end
         endcase
      end
   end

   assign dst_putn      = ~put;
   assign dst_word.data = pattern;
   assign dst_word.last = final_word;
   assign endn          = (state != F_END);

endmodule

// File: dma_pkg.sv
//################################################
// dma shared definitions
// word layout of both FIFOs and the descriptor
// control word fields decoded by the control block
//################################################

package dma_pkg;

   // a FIFO entry holds the payload and its end-of-block marker
   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } dma_word_t;

   // descriptor control word written by the host
   typedef logic [23:0] dc_t;

   // each engine has its own opcode bit in the descriptor
   localparam int DC_COPY_BIT = 4;
   localparam int DC_FILL_BIT = 5;

   // number of pattern words for a fill job
   localparam int DC_COUNT_LSB = 8;
   localparam int DC_COUNT_W   = 16;

endpackage

// File: dma_top.sv
//################################################
// dma block-move datapath
// source and destination FIFOs shared by the copy
// and fill engines under one descriptor register
//################################################

module dma_top #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                dc_we,
   input  dma_pkg::dc_t        dc_in,
   input  logic [63:0]         pattern_in,
   input  logic                src_putn,
   input  dma_pkg::dma_word_t  src_word,
   output logic                src_full,
   input  logic                dst_getn,
   output dma_pkg::dma_word_t  dst_word,
   output logic                dst_empty,
   output logic                busy,
   output logic                endn
);

   // source FIFO read side
   dma_pkg::dma_word_t src_rd_word;
   logic               src_empty;
   logic               src_getn;

   // destination FIFO write side
   dma_pkg::dma_word_t dst_wr_word;
   logic               dst_full;
   logic               dst_putn;

   // engine outputs before the control block selects one
   logic                           copy_go;
   logic                           copy_getn;
   logic                           copy_putn;
   dma_pkg::dma_word_t             copy_word;
   logic                           copy_endn;
   logic                           fill_go;
   logic                           fill_putn;
   dma_pkg::dma_word_t             fill_word;
   logic                           fill_endn;
   logic [dma_pkg::DC_COUNT_W-1:0] fill_count;
   logic [63:0]                    pattern;

   dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_src_fifo (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .putn         (src_putn),
      .wr_word      (src_word),
      .getn         (src_getn),
      .rd_word      (src_rd_word),
      .empty        (src_empty),
      .almost_empty (),
      .full         (src_full),
      .almost_full  ()
   );

   dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_dst_fifo (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .putn         (dst_putn),
      .wr_word      (dst_wr_word),
      .getn         (dst_getn),
      .rd_word      (dst_word),
      .empty        (dst_empty),
      .almost_empty (),
      .full         (dst_full),
      .almost_full  ()
   );

   dma_copy u_copy (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .go        (copy_go),
      .src_word  (src_rd_word),
      .src_empty (src_empty),
      .dst_full  (dst_full),
      .src_getn  (copy_getn),
      .dst_putn  (copy_putn),
      .dst_word  (copy_word),
      .endn      (copy_endn)
   );

   dma_fill u_fill (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .go       (fill_go),
      .count    (fill_count),
      .pattern  (pattern),
      .dst_full (dst_full),
      .dst_putn (fill_putn),
      .dst_word (fill_word),
      .endn     (fill_endn)
   );

   dma_ctrl u_ctrl (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .dc_we      (dc_we),
      .dc_in      (dc_in),
      .pattern_in (pattern_in),
      .copy_go    (copy_go),
      .fill_go    (fill_go),
      .fill_count (fill_count),
      .pattern    (pattern),
      .copy_getn  (copy_getn),
      .copy_putn  (copy_putn),
      .copy_word  (copy_word),
      .copy_endn  (copy_endn),
      .fill_putn  (fill_putn),
      .fill_word  (fill_word),
      .fill_endn  (fill_endn),
      .src_getn   (src_getn),
      .dst_putn   (dst_putn),
      .dst_word   (dst_wr_word),
      .endn       (endn),
      .busy       (busy)
   );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_dma -o tb_dma_sim
./obj_dir/tb_dma_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "Regression passed" sim.log; then
   echo "simulation stopped without a result"
   exit 1
fi
echo "simulation passed"

// File: tb_dma.sv
//################################################
// dma block-move testbench
// runs copy and fill jobs through the top level,
// checks the destination stream and end pulses
//################################################

module tb_dma;

   localparam int          FIFO_DEPTH = 8;
   localparam logic [31:0] SEED       = 32'd54454;
   // 48 words over all jobs, the 20-word copy at quarter-rate reads needs about
   // 100 cycles and the rest well under 50 each, so this leaves a wide margin
   localparam int          TIMEOUT_CYCLES = 4000;

   logic               wb_clk_i = 1'b0;
   logic               wb_rst_i;
   logic               dc_we;
   dma_pkg::dc_t       dc_in;
   logic [63:0]        pattern_in;
   logic               src_putn;
   dma_pkg::dma_word_t src_word;
   logic               src_full;
   logic               dst_getn = 1'b1;
   dma_pkg::dma_word_t dst_word;
   logic               dst_empty;
   logic               busy;
   logic               endn;

   dma_pkg::dma_word_t exp_q[$];
   dma_pkg::dma_word_t src_q[$];
   string              test_name   = "reset";
   logic [31:0]        rng_state   = SEED;
   logic [31:0]        stall_state = SEED;
   bit                 stall_mode  = 1'b0;
   int                 end_count   = 0;
   int                 cycles      = 0;

   dma_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .dc_we      (dc_we),
      .dc_in      (dc_in),
      .pattern_in (pattern_in),
      .src_putn   (src_putn),
      .src_word   (src_word),
      .src_full   (src_full),
      .dst_getn   (dst_getn),
      .dst_word   (dst_word),
      .dst_empty  (dst_empty),
      .busy       (busy),
      .endn       (endn)
   );

   always #2 wb_clk_i = ~wb_clk_i;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // two xorshift steps make one 64-bit data word
   task automatic random_data(output logic [63:0] value);
      rng_state     = xorshift(rng_state);
      value[63:32]  = rng_state;
      rng_state     = xorshift(rng_state);
      value[31:0]   = rng_state;
   endtask

   // word number idx of a job's destination stream, a copy forwards its source
   function automatic dma_pkg::dma_word_t expected_word(input bit fill, input int idx,
         input int len, input logic [63:0] pattern, input dma_pkg::dma_word_t src);
      dma_pkg::dma_word_t w;
      if (fill) begin
         w.data = pattern;
         w.last = (idx == len - 1);
      end else begin
         w = src;
      end
      return w;
   endfunction

   task automatic compare(input string name, input logic [64:0] expected,
         input logic [64:0] actual);
      if (actual !== expected) begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         $display("Regression failed");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // the reader only lowers getn when a word is there, in stall mode on one cycle in four
   always @(posedge wb_clk_i) begin
      #1;
      stall_state = xorshift(stall_state);
      if (!wb_rst_i && !dst_empty && (!stall_mode || stall_state[1:0] == 2'b00)) begin
         dst_getn = 1'b0;
      end else begin
         dst_getn = 1'b1;
      end
   end

   // a word leaves the destination FIFO on the next rising edge
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && !dst_getn && !dst_empty) begin
         if (exp_q.size() == 0) begin
            $display("the destination FIFO gave a word that no job should have produced");
            $display("Regression failed");
            $fatal(1, "unexpected destination word");
         end else begin
            compare(test_name, exp_q.pop_front(), dst_word);
         end
      end
   end

   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && !endn) begin
         end_count++;
      end
   end

   always @(posedge wb_clk_i) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("the run went past %0d cycles without finishing the tests", TIMEOUT_CYCLES);
         $display("Regression failed");
         $fatal(1, "timeout");
      end
   end

   // waits for the end pulse and the drained stream, then checks the idle state
   task automatic finish_job(input int ends_before);
      while (end_count == ends_before) @(posedge wb_clk_i);
      while (exp_q.size() != 0) @(posedge wb_clk_i);
      repeat (3) @(posedge wb_clk_i);
      #1;
      compare({test_name, "_end_pulses"}, 65'(ends_before + 1), 65'(end_count));
      compare({test_name, "_dst_empty"}, 65'(1), 65'(dst_empty));
      compare({test_name, "_busy"}, 65'(0), 65'(busy));
   endtask

   task automatic run_copy(input string name, input int n, input bit stall);
      dma_pkg::dma_word_t w;
      logic [63:0]        d;
      int                 i;
      int                 idx;
      int                 ends_before;
      bit                 started;
      bit                 full_seen;
      test_name   = name;
      stall_mode  = stall;
      ends_before = end_count;
      src_q.delete();
      for (i = 0; i < n; i++) begin
         random_data(d);
         w.data = d;
         w.last = (i == n - 1);
         src_q.push_back(w);
      end
      // the stream ends with the first word marked last
      for (i = 0; i < n; i++) begin
         exp_q.push_back(expected_word(1'b0, i, n, '0, src_q[i]));
         if (src_q[i].last) break;
      end
      idx       = 0;
      started   = 1'b0;
      full_seen = 1'b0;
      // the job starts once the source is full or holds the whole block
      while (idx < n || !started) begin
         @(posedge wb_clk_i);
         #1;
         dc_we    = 1'b0;
         src_putn = 1'b1;
         if (src_full) begin
            full_seen = 1'b1;
         end
         if (!started && (src_full || idx == n)) begin
            dc_in                       = '0;
            dc_in[dma_pkg::DC_COPY_BIT] = 1'b1;
            dc_we                       = 1'b1;
            started                     = 1'b1;
         end
         if (idx < n && !src_full) begin
            src_putn = 1'b0;
            src_word = src_q[idx];
            idx++;
         end
      end
      @(posedge wb_clk_i);
      #1;
      dc_we    = 1'b0;
      src_putn = 1'b1;
      if (n > FIFO_DEPTH) begin
         compare({name, "_src_full_seen"}, 65'(1), 65'(full_seen));
      end
      finish_job(ends_before);
   endtask

   task automatic run_fill(input string name, input int count, input logic [63:0] pat,
         input bit intrude);
      logic [63:0] d;
      int          i;
      int          ends_before;
      test_name   = name;
      stall_mode  = 1'b0;
      ends_before = end_count;
      for (i = 0; i < count; i++) begin
         exp_q.push_back(expected_word(1'b1, i, count, pat, '0));
      end
      @(posedge wb_clk_i);
      #1;
      dc_in                       = '0;
      dc_in[dma_pkg::DC_FILL_BIT] = 1'b1;
      dc_in[dma_pkg::DC_COUNT_LSB +: dma_pkg::DC_COUNT_W] = dma_pkg::DC_COUNT_W'(count);
      pattern_in                  = pat;
      dc_we                       = 1'b1;
      @(posedge wb_clk_i);
      #1;
      dc_we = 1'b0;
      if (intrude) begin
         compare({name, "_busy_running"}, 65'(1), 65'(busy));
         // a copy with a short fill and a new pattern, all of which must be ignored
         random_data(d);
         dc_in[dma_pkg::DC_COPY_BIT] = 1'b1;
         dc_in[dma_pkg::DC_COUNT_LSB +: dma_pkg::DC_COUNT_W] = dma_pkg::DC_COUNT_W'(5);
         pattern_in                  = d;
         dc_we                       = 1'b1;
         @(posedge wb_clk_i);
         #1;
         dc_we = 1'b0;
      end
      finish_job(ends_before);
   endtask

   initial begin
      logic [63:0] pat;
      wb_rst_i   = 1'b1;
      dc_we      = 1'b0;
      dc_in      = '0;
      pattern_in = '0;
      src_putn   = 1'b1;
      src_word   = '0;
      repeat (4) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;
      compare("reset_dst_empty", 65'(1), 65'(dst_empty));
      compare("reset_busy", 65'(0), 65'(busy));
      compare("reset_endn", 65'(1), 65'(endn));
      run_copy("copy_6", 6, 1'b0);
      run_copy("copy_20_stall", 20, 1'b1);
      random_data(pat);
      run_fill("fill_11", 11, pat, 1'b0);
      run_fill("fill_0", 0, pat, 1'b0);
      random_data(pat);
      run_fill("fill_write_while_busy", 11, pat, 1'b1);
      $display("Regression passed");
      $finish;
   end

endmodule
